/* src/sbus_pkg.sv */
// shared types and constants for the single-wire bus master
// state encoding is fixed at 4 bits
// DATA_WIDTH must not exceed ADDR_WIDTH, data rides left-aligned in the address-wide word
`default_nettype none

package sbus_pkg;

    typedef enum logic [3:0] {
        IDLE          = 4'd0,
        REQUEST       = 4'd1,
        GRANTED       = 4'd2,
        ADDR_SEND     = 4'd3,
        ADDR_ACK_WAIT = 4'd4,
        RETRY_WAIT    = 4'd5,
        WRITE_SEND    = 4'd6,
        DATA_ACK_WAIT = 4'd7,
        READ_WAIT     = 4'd8,
        READ_RECV     = 4'd9
    } master_state_e;

    // {previous bit, current bit} as seen on the line
    localparam logic [1:0] ADDR_ACK_PATTERN = 2'b00;  // two lows in a row
    localparam logic [1:0] DATA_ACK_PATTERN = 2'b01;  // low then high, also read data prefix

    localparam int DEF_ADDR_WIDTH  = 12;
    localparam int DEF_DATA_WIDTH  = 8;
    localparam int DEF_TIMEOUT_LEN = 4;  // ack wait is 2**(len-1) cycles

endpackage

`default_nettype wire

/* src/shift_link_if.sv */
// control link between the transaction FSM and the serial shifter
// bit_count has to stay stable for the whole frame
`default_nettype none

interface shift_link_if #(
    parameter int WORD_WIDTH = sbus_pkg::DEF_ADDR_WIDTH,
    parameter int CNT_WIDTH  = $clog2(WORD_WIDTH + 1)
);

    logic                  tx_start;   // one cycle pulse
    logic                  rx_start;   // one cycle pulse
    logic [CNT_WIDTH-1:0]  bit_count;  // payload bits, start bit not counted
    logic [WORD_WIDTH-1:0] tx_word;    // sent MSB first
    logic                  tx_done;    // high in the last bit's cycle
    logic                  rx_done;
    logic [WORD_WIDTH-1:0] rx_word;    // received bits, left-aligned

    modport ctrl (
        output tx_start, rx_start, bit_count, tx_word,
        input  tx_done, rx_done, rx_word
    );

    modport shifter (
        input  tx_start, rx_start, bit_count, tx_word,
        output tx_done, rx_done, rx_word
    );

endinterface

`default_nettype wire

/* src/serial_shifter.sv */
// frame shifter for the single-wire bus
// tx: start bit 0 then bit_count bits MSB first, bus_oe high for 1+N cycles
// rx: first bit is sampled on the edge that sees rx_start, result is left-aligned
`default_nettype none

module serial_shifter #(
    parameter int WORD_WIDTH = sbus_pkg::DEF_ADDR_WIDTH,
    parameter int CNT_WIDTH  = $clog2(WORD_WIDTH + 1)
) (
    input  logic          clk,
    input  logic          rstn,
    input  logic          bus_in,
    output logic          bus_out,
    output logic          bus_oe,
    shift_link_if.shifter link
);

    typedef enum logic [1:0] {
        SH_IDLE,
        SH_TX,
        SH_RX
    } shift_mode_e;

    shift_mode_e           mode;
    logic [WORD_WIDTH-1:0] sreg;
    logic [CNT_WIDTH-1:0]  cnt;       // bits done in this frame
    logic                  last_bit;

    assign last_bit     = (cnt == link.bit_count - 1'b1);
    assign link.rx_word = sreg;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            mode         <= SH_IDLE;
            cnt          <= '0;
            bus_out      <= 1'b1;  // line idles high
            bus_oe       <= 1'b0;
            link.tx_done <= 1'b0;
            link.rx_done <= 1'b0;
        end
        else
        begin
            link.tx_done <= 1'b0;
            link.rx_done <= 1'b0;
            if (link.tx_start)
            begin
                mode    <= SH_TX;
                cnt     <= '0;
                bus_oe  <= 1'b1;
                bus_out <= 1'b0;  // start bit
            end
            else if (link.rx_start)
            begin
                cnt <= CNT_WIDTH'(1);  // first bit taken on this edge
                if (link.bit_count == CNT_WIDTH'(1))
                begin
                    mode         <= SH_IDLE;
                    link.rx_done <= 1'b1;
                end
                else
                    mode <= SH_RX;
            end
            else
            begin
                case (mode)
                    SH_TX:
                    begin
                        if (cnt == link.bit_count)
                        begin
                            mode    <= SH_IDLE;
                            bus_oe  <= 1'b0;
                            bus_out <= 1'b1;
                        end
                        else
                        begin
                            bus_out      <= sreg[WORD_WIDTH-1];
                            cnt          <= cnt + 1'b1;
                            link.tx_done <= last_bit;
                        end
                    end
                    SH_RX:
                    begin
                        cnt <= cnt + 1'b1;
                        if (last_bit)
                        begin
                            mode         <= SH_IDLE;
                            link.rx_done <= 1'b1;
                        end
                    end
                    default: mode <= SH_IDLE;
                endcase
            end
        end
    end

    // shift register, one word for both directions
    always_ff @(posedge clk)
    begin
        if (link.tx_start)
            sreg <= link.tx_word;
        else if (link.rx_start)
            sreg <= {bus_in, {(WORD_WIDTH-1){1'b0}}};  // clear the unused low bits
        else if (mode == SH_TX && cnt != link.bit_count)
            sreg <= sreg << 1;
        else if (mode == SH_RX)
            sreg[WORD_WIDTH-1-cnt] <= bus_in;
    end

endmodule

`default_nettype wire

/* src/bus_master_fsm.sv */
// transaction FSM: arbitration, address/data frames, ack detection, address-ack retry
// acks are found by comparing the previous and current sampled bus_in bits
// data ack and read prefix have no timeout and only count while grant is high
`default_nettype none

module bus_master_fsm #(
    parameter int ADDR_WIDTH  = sbus_pkg::DEF_ADDR_WIDTH,
    parameter int DATA_WIDTH  = sbus_pkg::DEF_DATA_WIDTH,
    parameter int TIMEOUT_LEN = sbus_pkg::DEF_TIMEOUT_LEN,
    parameter int CNT_WIDTH   = $clog2(ADDR_WIDTH + 1)
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  hold,
    input  logic                  execute,
    input  logic                  rw,         // 1 = write
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic [DATA_WIDTH-1:0] wdata,
    input  logic                  grant,
    input  logic                  bus_in,
    output logic [DATA_WIDTH-1:0] rdata,
    output logic                  done,
    output logic                  busy,
    output logic                  request,
    output logic                  bus_rw,
    output logic                  bus_owned,
    shift_link_if.ctrl            link
);

    localparam int ACK_WAIT = 2 ** (TIMEOUT_LEN - 1);

    sbus_pkg::master_state_e state;
    logic                    rw_q;
    logic [ADDR_WIDTH-1:0]   addr_q;
    logic [DATA_WIDTH-1:0]   wdata_q;
    logic [TIMEOUT_LEN-1:0]  timer;     // ack wait, then bus release time
    logic                    prev_bit;
    logic [1:0]              bit_pair;
    logic                    timer_end;
    logic                    exec_accept;
    logic                    regrant;
    logic                    addr_acked;

    assign bit_pair    = {prev_bit, bus_in};
    assign timer_end   = (timer == TIMEOUT_LEN'(ACK_WAIT - 1));
    assign exec_accept = (state == sbus_pkg::GRANTED) && hold && grant && execute;
    assign regrant     = (state == sbus_pkg::RETRY_WAIT) && request && grant;
    assign addr_acked  = (state == sbus_pkg::ADDR_ACK_WAIT) &&
                         (bit_pair == sbus_pkg::ADDR_ACK_PATTERN);

    // latched transaction and the word handed to the shifter
    always_ff @(posedge clk)
    begin
        if (exec_accept)
        begin
            addr_q       <= addr;
            wdata_q      <= wdata;
            link.tx_word <= addr;
        end
        else if (regrant)
            link.tx_word <= addr_q;  // same address again after timeout
        else if (addr_acked)
            link.tx_word <= ADDR_WIDTH'(wdata_q) << (ADDR_WIDTH - DATA_WIDTH);
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state          <= sbus_pkg::IDLE;
            rw_q           <= 1'b0;
            timer          <= '0;
            prev_bit       <= 1'b1;
            rdata          <= '0;
            done           <= 1'b0;
            busy           <= 1'b0;
            request        <= 1'b0;
            bus_rw         <= 1'b0;
            bus_owned      <= 1'b0;
            link.tx_start  <= 1'b0;
            link.rx_start  <= 1'b0;
            link.bit_count <= '0;
        end
        else
        begin
            done          <= 1'b0;
            link.tx_start <= 1'b0;
            link.rx_start <= 1'b0;
            case (state)
                sbus_pkg::IDLE:
                begin
                    if (hold)
                    begin
                        request <= 1'b1;
                        busy    <= 1'b1;
                        state   <= sbus_pkg::REQUEST;
                    end
                end
                sbus_pkg::REQUEST:
                begin
                    if (grant)
                    begin
                        bus_owned <= 1'b1;
                        busy      <= 1'b0;
                        state     <= sbus_pkg::GRANTED;
                    end
                end
                sbus_pkg::GRANTED:
                begin
                    if (!hold)
                    begin
                        request   <= 1'b0;
                        bus_owned <= 1'b0;
                        state     <= sbus_pkg::IDLE;
                    end
                    else if (!grant)
                    begin
                        bus_owned <= 1'b0;  // lost the bus, ask again
                        busy      <= 1'b1;
                        state     <= sbus_pkg::REQUEST;
                    end
                    else if (exec_accept)
                    begin
                        rw_q           <= rw;
                        bus_rw         <= rw;
                        busy           <= 1'b1;
                        link.tx_start  <= 1'b1;
                        link.bit_count <= CNT_WIDTH'(ADDR_WIDTH);
                        state          <= sbus_pkg::ADDR_SEND;
                    end
                end
                sbus_pkg::ADDR_SEND:
                begin
                    if (link.tx_done)
                    begin
                        timer    <= '0;
                        prev_bit <= 1'b1;  // ignore our own last bit
                        state    <= sbus_pkg::ADDR_ACK_WAIT;
                    end
                end
                sbus_pkg::ADDR_ACK_WAIT:
                begin
                    prev_bit <= bus_in;
                    if (addr_acked)
                    begin
                        prev_bit <= 1'b1;
                        if (rw_q)
                        begin
                            link.tx_start  <= 1'b1;
                            link.bit_count <= CNT_WIDTH'(DATA_WIDTH);
                            state          <= sbus_pkg::WRITE_SEND;
                        end
                        else
                            state <= sbus_pkg::READ_WAIT;
                    end
                    else if (timer_end)
                    begin
                        request   <= 1'b0;  // give the bus up for ACK_WAIT cycles
                        bus_owned <= 1'b0;
                        bus_rw    <= 1'b0;
                        timer     <= '0;
                        state     <= sbus_pkg::RETRY_WAIT;
                    end
                    else
                        timer <= timer + 1'b1;
                end
                sbus_pkg::RETRY_WAIT:
                begin
                    // request low means still in the release phase
                    if (!request)
                    begin
                        timer <= timer + 1'b1;
                        if (timer_end)
                            request <= 1'b1;
                    end
                    else if (regrant)
                    begin
                        bus_owned      <= 1'b1;
                        bus_rw         <= rw_q;
                        link.tx_start  <= 1'b1;
                        link.bit_count <= CNT_WIDTH'(ADDR_WIDTH);
                        state          <= sbus_pkg::ADDR_SEND;
                    end
                end
                sbus_pkg::WRITE_SEND:
                begin
                    if (link.tx_done)
                    begin
                        prev_bit <= 1'b1;
                        state    <= sbus_pkg::DATA_ACK_WAIT;
                    end
                end
                sbus_pkg::DATA_ACK_WAIT:
                begin
                    bus_owned <= grant;
                    bus_rw    <= grant;  // only writes get here
                    if (grant)
                    begin
                        prev_bit <= bus_in;
                        if (bit_pair == sbus_pkg::DATA_ACK_PATTERN)
                        begin
                            done   <= 1'b1;
                            busy   <= 1'b0;
                            bus_rw <= 1'b0;
                            state  <= sbus_pkg::GRANTED;
                        end
                    end
                    else
                        prev_bit <= 1'b1;
                end
                sbus_pkg::READ_WAIT:
                begin
                    bus_owned <= grant;
                    if (grant)
                    begin
                        prev_bit <= bus_in;
                        if (bit_pair == sbus_pkg::DATA_ACK_PATTERN)
                        begin
                            link.rx_start  <= 1'b1;  // data follows the prefix directly
                            link.bit_count <= CNT_WIDTH'(DATA_WIDTH);
                            state          <= sbus_pkg::READ_RECV;
                        end
                    end
                    else
                        prev_bit <= 1'b1;
                end
                sbus_pkg::READ_RECV:
                begin
                    if (link.rx_done)
                    begin
                        rdata <= link.rx_word[ADDR_WIDTH-1 -: DATA_WIDTH];
                        done  <= 1'b1;
                        busy  <= 1'b0;
                        state <= sbus_pkg::GRANTED;
                    end
                end
                default: state <= sbus_pkg::IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/bus_master.sv */
// single-wire bus master, top level
// bus_in is the sampled line, bus_out/bus_oe drive it when this master sends
// all outputs are registered, DATA_WIDTH must not exceed ADDR_WIDTH
`default_nettype none

module bus_master #(
    parameter int ADDR_WIDTH  = sbus_pkg::DEF_ADDR_WIDTH,
    parameter int DATA_WIDTH  = sbus_pkg::DEF_DATA_WIDTH,
    parameter int TIMEOUT_LEN = sbus_pkg::DEF_TIMEOUT_LEN
) (
    input  logic                  clk,
    input  logic                  rstn,
    // client side
    input  logic                  hold,
    input  logic                  execute,
    input  logic                  rw,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic [DATA_WIDTH-1:0] wdata,
    output logic [DATA_WIDTH-1:0] rdata,
    output logic                  done,
    output logic                  busy,
    // bus side
    input  logic                  grant,
    input  logic                  bus_in,
    output logic                  request,
    output logic                  bus_out,
    output logic                  bus_oe,
    output logic                  bus_rw,
    output logic                  bus_owned
);

    localparam int CNT_WIDTH = $clog2(ADDR_WIDTH + 1);

    shift_link_if #(
        .WORD_WIDTH (ADDR_WIDTH),
        .CNT_WIDTH  (CNT_WIDTH)
    ) link_i ();

    bus_master_fsm #(
        .ADDR_WIDTH  (ADDR_WIDTH),
        .DATA_WIDTH  (DATA_WIDTH),
        .TIMEOUT_LEN (TIMEOUT_LEN),
        .CNT_WIDTH   (CNT_WIDTH)
    ) fsm_i (
        .clk       (clk),
        .rstn      (rstn),
        .hold      (hold),
        .execute   (execute),
        .rw        (rw),
        .addr      (addr),
        .wdata     (wdata),
        .grant     (grant),
        .bus_in    (bus_in),
        .rdata     (rdata),
        .done      (done),
        .busy      (busy),
        .request   (request),
        .bus_rw    (bus_rw),
        .bus_owned (bus_owned),
        .link      (link_i.ctrl)
    );

    serial_shifter #(
        .WORD_WIDTH (ADDR_WIDTH),
        .CNT_WIDTH  (CNT_WIDTH)
    ) shifter_i (
        .clk     (clk),
        .rstn    (rstn),
        .bus_in  (bus_in),
        .bus_out (bus_out),
        .bus_oe  (bus_oe),
        .link    (link_i.shifter)
    );

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
// clock and reset source for the testbench
// rstn is released 1 time unit after the last reset edge
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rstn
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rstn = 1'b1;
    end

endmodule

`default_nettype wire

/* verif/bus_slave_model.sv */
// arbiter and serial slave model, works 1 time unit after each rising edge
// a frame of ADDR_WIDTH+1 bits is an address, any other length is write data
// gaps before each response are random, 0 to 3 idle cycles
`default_nettype none

module bus_slave_model #(
    parameter int ADDR_WIDTH = 12,
    parameter int DATA_WIDTH = 8
) (
    input  wire                   clk,
    input  wire                   rstn,
    input  wire                   request,
    input  wire                   bus_out,
    input  wire                   bus_oe,
    input  wire                   bus_rw,
    input  wire  [DATA_WIDTH-1:0] read_value,
    input  wire                   skip_addr,   // ignore the first address frame
    output logic                  grant,
    output logic                  bus_in,
    output logic [ADDR_WIDTH:0]   addr_frame,
    output logic [ADDR_WIDTH:0]   prev_addr_frame,
    output logic [DATA_WIDTH:0]   data_frame,
    output logic                  addr_rw,
    output logic                  data_rw,
    output int                    addr_frames
);

    logic              slave_out;
    logic [ADDR_WIDTH:0] shreg;
    logic              in_frame;
    logic              frame_rw;
    logic              skipped;
    int                nbits;
    int                seed = 34312;
    bit                resp[$];

    assign bus_in = bus_oe ? bus_out : slave_out;  // single line, idles high

    task automatic push_gap();
        int gap;
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) resp.push_back(1'b1);
    endtask

    task automatic push_pair(input bit first, input bit second);
        resp.push_back(first);
        resp.push_back(second);
    endtask

    task automatic finish_frame();
        if (nbits == ADDR_WIDTH + 1)
        begin
            prev_addr_frame = addr_frame;
            addr_frame      = shreg;
            addr_rw         = frame_rw;
            addr_frames++;
            if (skip_addr && !skipped)
                skipped = 1'b1;  // no ack, master has to time out
            else
            begin
                skipped = 1'b0;  // next retry line skips its first frame again
                push_gap();
                push_pair(1'b0, 1'b0);
                if (!frame_rw)
                begin
                    push_gap();
                    push_pair(1'b0, 1'b1);
                    for (int i = DATA_WIDTH - 1; i >= 0; i--)
                        resp.push_back(read_value[i]);
                end
            end
        end
        else
        begin
            data_frame = shreg[DATA_WIDTH:0];
            data_rw    = frame_rw;
            push_gap();
            push_pair(1'b0, 1'b1);
        end
    endtask

    initial
    begin
        grant           = 1'b0;
        slave_out       = 1'b1;
        in_frame        = 1'b0;
        skipped         = 1'b0;
        nbits           = 0;
        addr_frames     = 0;
        addr_frame      = '0;
        prev_addr_frame = '0;
        data_frame      = '0;
        addr_rw         = 1'b0;
        data_rw         = 1'b0;
        forever
        begin
            @(posedge clk);
            #1;
            if (rstn)
            begin
                grant = request;  // one cycle behind request, both ways
                if (bus_oe)
                begin
                    if (!in_frame)
                    begin
                        shreg    = '0;
                        nbits    = 0;
                        frame_rw = 1'b1;
                    end
                    in_frame = 1'b1;
                    shreg    = {shreg[ADDR_WIDTH-1:0], bus_out};
                    frame_rw = frame_rw & bus_rw;
                    nbits++;
                end
                else if (in_frame)
                begin
                    in_frame = 1'b0;
                    finish_frame();
                end
                slave_out = (resp.size() > 0) ? resp.pop_front() : 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* verif/bus_master_tb.sv */
// testbench for bus_master with default widths, stimulus from verif/bus_master_stim.txt
// inputs change 1 time unit after the rising edge, outputs are sampled there too
`default_nettype none

module bus_master_tb;

    localparam int AW       = 12;
    localparam int DW       = 8;
    localparam int TL       = 4;
    localparam int ACK_WAIT = 2 ** (TL - 1);
    localparam int LINE_CYCLES = 4 * (AW + DW) + 4 * ACK_WAIT + 20;

    wire           clk;
    wire           rstn;
    logic          hold;
    logic          execute;
    logic          rw;
    logic [AW-1:0] addr;
    logic [DW-1:0] wdata;
    wire  [DW-1:0] rdata;
    wire           done;
    wire           busy;
    wire           grant;
    wire           bus_in;
    wire           request;
    wire           bus_out;
    wire           bus_oe;
    wire           bus_rw;
    wire           bus_owned;
    logic [DW-1:0] read_value;
    logic          skip_addr;
    wire  [AW:0]   addr_frame;
    wire  [AW:0]   prev_addr_frame;
    wire  [DW:0]   data_frame;
    wire           addr_rw;
    wire           data_rw;
    int            addr_frames;

    int            stim_op[$];
    logic [AW-1:0] stim_addr[$];
    logic [DW-1:0] stim_wdata[$];
    logic [DW-1:0] stim_rval[$];
    logic          stim_retry[$];
    int            cycles = 0;
    int            limit = 0;

    tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(5)) clk_gen_i (.clk(clk), .rstn(rstn));

    bus_master #(.ADDR_WIDTH(AW), .DATA_WIDTH(DW), .TIMEOUT_LEN(TL)) bus_master_i (
        .clk(clk), .rstn(rstn), .hold(hold), .execute(execute), .rw(rw),
        .addr(addr), .wdata(wdata), .rdata(rdata), .done(done), .busy(busy),
        .grant(grant), .bus_in(bus_in), .request(request), .bus_out(bus_out),
        .bus_oe(bus_oe), .bus_rw(bus_rw), .bus_owned(bus_owned)
    );

    bus_slave_model #(.ADDR_WIDTH(AW), .DATA_WIDTH(DW)) slave_i (
        .clk(clk), .rstn(rstn), .request(request), .bus_out(bus_out), .bus_oe(bus_oe),
        .bus_rw(bus_rw), .read_value(read_value), .skip_addr(skip_addr),
        .grant(grant), .bus_in(bus_in), .addr_frame(addr_frame),
        .prev_addr_frame(prev_addr_frame), .data_frame(data_frame),
        .addr_rw(addr_rw), .data_rw(data_rw), .addr_frames(addr_frames)
    );

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string test, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act)
        else
            stop_on_error($sformatf("CHECK FAILED %s: expected 0x%0h, actual 0x%0h",
                                    test, exp, act));
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    always @(posedge clk)
    begin
        cycles++;
        if (limit > 0 && cycles > limit)
            stop_on_error($sformatf("timeout: run still going after %0d cycles", limit));
    end

    task automatic load_stimulus();
        int            fd;
        int            r;
        int            op;
        logic [AW-1:0] a;
        logic [DW-1:0] d;
        logic [DW-1:0] rv;
        logic          rt;
        string         line;
        fd = $fopen("verif/bus_master_stim.txt", "r");
        if (fd == 0)
            stop_on_error("could not open the stimulus file verif/bus_master_stim.txt");
        while (!$feof(fd))
        begin
            r = $fscanf(fd, "%h %h %h %h %h\n", op, a, d, rv, rt);
            if (r == 5)
            begin
                stim_op.push_back(op);
                stim_addr.push_back(a);
                stim_wdata.push_back(d);
                stim_rval.push_back(rv);
                stim_retry.push_back(rt);
            end
            else
                r = $fgets(line, fd);  // skip a comment line
        end
        $fclose(fd);
        if (stim_op.size() == 0)
            stop_on_error("the stimulus file holds no transactions");
    endtask

    task automatic release_bus();
        hold = 1'b0;
        while (request)
            next_cycle();
        check_value("release bus_owned", 0, bus_owned);
        repeat (3)
        begin
            next_cycle();
            check_value("release busy", 0, busy);
            check_value("release request", 0, request);
        end
    endtask

    task automatic run_transaction(input int op, input logic [AW-1:0] a, input logic [DW-1:0] d,
                                   input logic [DW-1:0] rv, input logic rt);
        int   frames0;
        int   falls;
        int   rises;
        int   low_cycles;
        logic req_prev;
        if (!hold)
        begin
            hold = 1'b1;
            while (!bus_owned)
                next_cycle();
            check_value("grant busy", 0, busy);
        end
        read_value = rv;
        skip_addr  = rt;
        frames0    = addr_frames;
        execute    = 1'b1;
        rw         = (op == 1);
        addr       = a;
        wdata      = d;
        next_cycle();
        execute = 1'b0;
        check_value("busy after execute", 1, busy);
        req_prev   = request;
        falls      = 0;
        rises      = 0;
        low_cycles = 0;
        while (!done)
        begin
            next_cycle();
            if (req_prev && !request)
                falls++;
            if (!req_prev && request)
                rises++;
            if (!request)
                low_cycles++;
            req_prev = request;
        end
        check_value("busy at done", 0, busy);
        check_value("address frame", {1'b0, a}, addr_frame);
        check_value("bus_rw on address frame", (op == 1), addr_rw);
        if (op == 1)
        begin
            check_value("write data frame", {1'b0, d}, data_frame);
            check_value("bus_rw on data frame", 1, data_rw);
        end
        else
            check_value("read data", rv, rdata);
        if (rt)
        begin
            check_value("retry request falls", 1, falls);
            check_value("retry request rises", 1, rises);
            check_value("retry request low cycles", ACK_WAIT, low_cycles);
            check_value("retry address frames", 2, addr_frames - frames0);
            check_value("retry resent address", prev_addr_frame, addr_frame);
        end
        else
            check_value("address frames", 1, addr_frames - frames0);
        skip_addr = 1'b0;
        next_cycle();
        check_value("done pulse width", 0, done);
    endtask

    initial
    begin
        hold       = 1'b0;
        execute    = 1'b0;
        rw         = 1'b0;
        addr       = '0;
        wdata      = '0;
        read_value = '0;
        skip_addr  = 1'b0;
        load_stimulus();
        limit = stim_op.size() * LINE_CYCLES;
        @(posedge rstn);
        repeat (2) next_cycle();
        check_value("reset request", 0, request);
        check_value("reset busy", 0, busy);
        check_value("reset done", 0, done);
        check_value("reset bus_oe", 0, bus_oe);
        check_value("reset bus_owned", 0, bus_owned);
        foreach (stim_op[i])
        begin
            if (stim_op[i] == 2)
                release_bus();
            else
                run_transaction(stim_op[i], stim_addr[i], stim_wdata[i], stim_rval[i],
                                stim_retry[i]);
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/bus_master_stim.txt */
// op addr wdata read_value retry, all hex; op 1 = write, 0 = read, 2 = release hold
// retry 1 makes the slave ignore the first address frame of that line
1 a5c 3c 00 0
0 a5c 00 c3 0
1 0ff 81 00 1
0 123 00 5a 1
2 000 00 00 0
1 fff ff 00 0
0 800 00 01 0
0 001 00 fe 0
1 7e1 00 00 0
2 000 00 00 0
0 456 00 a7 0
1 abc 55 00 1

/* tb.f */
src/sbus_pkg.sv
src/shift_link_if.sv
src/serial_shifter.sv
src/bus_master_fsm.sv
src/bus_master.sv
verif/tb_clock_gen.sv
verif/bus_slave_model.sv
verif/bus_master_tb.sv

/* Bender.yml */
package:
  name: bus_master

sources:
  - src/sbus_pkg.sv
  - src/shift_link_if.sv
  - src/serial_shifter.sv
  - src/bus_master_fsm.sv
  - src/bus_master.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/bus_slave_model.sv
      - verif/bus_master_tb.sv
